/* cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// processor and memory address width
`define CACHE_ADDR_W 32

// data word width, strobe width is CACHE_DATA_W/8
`define CACHE_DATA_W 32

// number of lines in the direct-mapped array
`define CACHE_NUM_SETS 4

// byte offset bits inside one word-sized line
`define CACHE_OFFSET_W 2

`endif

/* axil_pkg.sv */
`include "cache_config.svh"

package axil_pkg;

  // response codes for R and B
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // address channel payload, shared by AR and AW
  typedef struct packed {
    logic [`CACHE_ADDR_W-1:0] addr;
    logic [2:0]               prot;
  } axil_ax_t;

  // write data payload
  typedef struct packed {
    logic [`CACHE_DATA_W-1:0]   data;
    logic [`CACHE_DATA_W/8-1:0] strb;
  } axil_w_t;

  // read data payload
  typedef struct packed {
    logic [`CACHE_DATA_W-1:0] data;
    axil_resp_e               resp;
  } axil_r_t;

  // write response payload
  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

endpackage

/* cache_pkg.sv */
`include "cache_config.svh"

package cache_pkg;

  localparam int index_w = $clog2(`CACHE_NUM_SETS);
  localparam int tag_w   = `CACHE_ADDR_W - index_w - `CACHE_OFFSET_W;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cache_op_e;

  typedef logic [index_w-1:0] cache_index_t;
  typedef logic [tag_w-1:0]   cache_tag_t;

  // one processor access, word aligned
  typedef struct packed {
    cache_op_e                  op;
    logic [`CACHE_ADDR_W-1:0]   addr;
    logic [`CACHE_DATA_W-1:0]   data;
    logic [`CACHE_DATA_W/8-1:0] strb;
  } cache_req_t;

  typedef struct packed {
    cache_op_e                op;
    logic [`CACHE_DATA_W-1:0] data;
  } cache_rsp_t;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_MEM_WAIT,
    CTRL_RESPOND
  } ctrl_state_e;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_ADDR,
    MEM_READ_WAIT,
    MEM_WRITE_WAIT
  } mem_state_e;

endpackage

/* cache_proc_port.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_proc_port (
  input  logic                  ACLK,
  input  logic                  ARESETn,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  axil_pkg::axil_ax_t    ar,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axil_pkg::axil_ax_t    aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  axil_pkg::axil_w_t     w,
  output logic                  r_valid,
  input  logic                  r_ready,
  output axil_pkg::axil_r_t     r,
  output logic                  b_valid,
  input  logic                  b_ready,
  output axil_pkg::axil_b_t     b,
  output logic                  req_valid,
  input  logic                  req_ready,
  output cache_pkg::cache_req_t req,
  input  logic                  rsp_valid,
  output logic                  rsp_ready,
  input  cache_pkg::cache_rsp_t rsp
);

  logic                     busy;
  logic                     rd_accept;
  logic                     wr_accept;
  logic [`CACHE_DATA_W-1:0] rdata_q;

  assign ar_ready = !busy;
  // a write needs AW and W together and yields to a pending read
  assign aw_ready = !busy && !ar_valid && (aw_valid == w_valid);
  assign w_ready  = aw_ready;

  assign rd_accept = ar_valid && ar_ready;
  assign wr_accept = aw_valid && w_valid && aw_ready;

  // busy spans from acceptance to the R or B transfer
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
    end else begin
      if (rd_accept || wr_accept) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
      end else if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end
      if ((r_valid && r_ready) || (b_valid && b_ready)) begin
        busy <= 1'b0;
      end
    end
  end

  // prot is dropped here
  always_ff @(posedge ACLK) begin
    if (rd_accept) begin
      req <= '{op: cache_pkg::OP_READ, addr: ar.addr, data: '0, strb: '0};
    end else if (wr_accept) begin
      req <= '{op: cache_pkg::OP_WRITE, addr: aw.addr, data: w.data, strb: w.strb};
    end
  end

  assign rsp_ready = !r_valid && !b_valid;

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (rsp_valid && rsp_ready) begin
        if (rsp.op == cache_pkg::OP_READ) begin
          r_valid <= 1'b1;
        end else begin
          b_valid <= 1'b1;
        end
      end
      if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (rsp_valid && rsp_ready) begin
      rdata_q <= rsp.data;
    end
  end

  assign r = '{data: rdata_q, resp: axil_pkg::OKAY};
  assign b = '{resp: axil_pkg::OKAY};

  // only word-aligned accesses reach the cache
  a_ar_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_accept |-> ar.addr[`CACHE_OFFSET_W-1:0] == '0);
  a_aw_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wr_accept |-> aw.addr[`CACHE_OFFSET_W-1:0] == '0);

  // nothing of an earlier access may still be in flight
  a_single: assert property (@(posedge ACLK) disable iff (!ARESETn)
    (rd_accept || wr_accept) |-> !req_valid && !r_valid && !b_valid);

endmodule

/* cache_store.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store (
  input  logic                       ACLK,
  input  logic                       ARESETn,
  input  cache_pkg::cache_index_t    index,
  input  cache_pkg::cache_tag_t      tag,
  input  logic                       fill_en,
  input  logic [`CACHE_DATA_W-1:0]   fill_data,
  input  logic                       wr_en,
  input  logic [`CACHE_DATA_W/8-1:0] wr_strb,
  input  logic [`CACHE_DATA_W-1:0]   wr_data,
  output logic                       hit,
  output logic [`CACHE_DATA_W-1:0]   line_data
);

  logic [`CACHE_DATA_W-1:0] data_q [`CACHE_NUM_SETS];
  cache_pkg::cache_tag_t    tag_q [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_q;

  assign hit       = valid_q[index] && (tag_q[index] == tag);
  assign line_data = data_q[index];

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[index] <= 1'b1;
    end
  end

  // a fill replaces the whole line, a write hit merges strobed bytes only
  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      data_q[index] <= fill_data;
      tag_q[index]  <= tag;
    end else if (wr_en && hit) begin
      for (int i = 0; i < `CACHE_DATA_W/8; i++) begin
        if (wr_strb[i]) begin
          data_q[index][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

/* cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic                     req_valid,
  output logic                     req_ready,
  input  cache_pkg::cache_req_t    req,
  output logic                     rsp_valid,
  input  logic                     rsp_ready,
  output cache_pkg::cache_rsp_t    rsp,
  output logic                     mreq_valid,
  input  logic                     mreq_ready,
  output cache_pkg::cache_req_t    mreq,
  input  logic                     mrsp_valid,
  output logic                     mrsp_ready,
  input  logic [`CACHE_DATA_W-1:0] mrsp_data
);

  cache_pkg::ctrl_state_e   state;
  cache_pkg::cache_req_t    req_q;
  logic [`CACHE_ADDR_W-1:0] lk_addr;
  cache_pkg::cache_index_t  index;
  cache_pkg::cache_tag_t    tag;
  logic                     hit;
  logic [`CACHE_DATA_W-1:0] line_data;
  logic                     req_fire;
  logic                     mrsp_fire;
  logic                     fill_en;
  logic                     wr_en;

  assign req_ready  = (state == cache_pkg::CTRL_IDLE);
  assign mrsp_ready = (state == cache_pkg::CTRL_MEM_WAIT) && !mreq_valid;
  assign req_fire   = req_valid && req_ready;
  assign mrsp_fire  = mrsp_valid && mrsp_ready;

  // look up the incoming request while idle, the held one while waiting
  assign lk_addr = req_ready ? req.addr : req_q.addr;
  assign index   = lk_addr[`CACHE_OFFSET_W +: cache_pkg::index_w];
  assign tag     = lk_addr[`CACHE_ADDR_W-1 -: cache_pkg::tag_w];

  assign fill_en = mrsp_fire && (req_q.op == cache_pkg::OP_READ);
  // write-through completes first, then a hit line is merged
  assign wr_en   = mrsp_fire && (req_q.op == cache_pkg::OP_WRITE);
  assign mreq    = req_q;

  cache_store u_store (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .index     (index),
    .tag       (tag),
    .fill_en   (fill_en),
    .fill_data (mrsp_data),
    .wr_en     (wr_en),
    .wr_strb   (req_q.strb),
    .wr_data   (req_q.data),
    .hit       (hit),
    .line_data (line_data)
  );

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state      <= cache_pkg::CTRL_IDLE;
      rsp_valid  <= 1'b0;
      mreq_valid <= 1'b0;
    end else begin
      case (state)
        cache_pkg::CTRL_IDLE: begin
          if (req_fire) begin
            if (req.op == cache_pkg::OP_READ && hit) begin
              rsp_valid <= 1'b1;
              state     <= cache_pkg::CTRL_RESPOND;
            end else begin
              mreq_valid <= 1'b1;
              state      <= cache_pkg::CTRL_MEM_WAIT;
            end
          end
        end
        cache_pkg::CTRL_MEM_WAIT: begin
          if (mreq_valid && mreq_ready) begin
            mreq_valid <= 1'b0;
          end
          if (mrsp_fire) begin
            rsp_valid <= 1'b1;
            state     <= cache_pkg::CTRL_RESPOND;
          end
        end
        cache_pkg::CTRL_RESPOND: begin
          if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= cache_pkg::CTRL_IDLE;
          end
        end
        default: state <= cache_pkg::CTRL_IDLE;
      endcase
    end
  end

  // a hit answers from the line, a miss or write from memory
  always_ff @(posedge ACLK) begin
    if (req_fire) begin
      req_q <= req;
      rsp   <= '{op: req.op, data: line_data};
    end else if (mrsp_fire) begin
      rsp <= '{op: req_q.op, data: mrsp_data};
    end
  end

  a_idle_no_mreq: assert property (@(posedge ACLK) disable iff (!ARESETn)
    state == cache_pkg::CTRL_IDLE |-> !mreq_valid);

endmodule

/* cache_mem_port.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_mem_port (
  input  logic                     ACLK,
  input  logic                     ARESETn,
  input  logic                     mreq_valid,
  output logic                     mreq_ready,
  input  cache_pkg::cache_req_t    mreq,
  output logic                     mrsp_valid,
  input  logic                     mrsp_ready,
  output logic [`CACHE_DATA_W-1:0] mrsp_data,
  output logic                     m_ar_valid,
  input  logic                     m_ar_ready,
  output axil_pkg::axil_ax_t       m_ar,
  output logic                     m_aw_valid,
  input  logic                     m_aw_ready,
  output axil_pkg::axil_ax_t       m_aw,
  output logic                     m_w_valid,
  input  logic                     m_w_ready,
  output axil_pkg::axil_w_t        m_w,
  input  logic                     m_r_valid,
  output logic                     m_r_ready,
  input  axil_pkg::axil_r_t        m_r,
  input  logic                     m_b_valid,
  output logic                     m_b_ready,
  input  axil_pkg::axil_b_t        m_b
);

  cache_pkg::mem_state_e state;
  cache_pkg::cache_req_t req_q;
  logic                  is_wr;
  logic                  aw_done;
  logic                  w_done;
  logic                  aw_fin;
  logic                  w_fin;

  assign mreq_ready = (state == cache_pkg::MEM_IDLE) && !mrsp_valid;
  assign is_wr      = (req_q.op == cache_pkg::OP_WRITE);

  // AW and W start together and each drops after its own transfer
  assign m_ar_valid = (state == cache_pkg::MEM_ADDR) && !is_wr;
  assign m_aw_valid = (state == cache_pkg::MEM_ADDR) && is_wr && !aw_done;
  assign m_w_valid  = (state == cache_pkg::MEM_ADDR) && is_wr && !w_done;
  assign aw_fin     = aw_done || (m_aw_valid && m_aw_ready);
  assign w_fin      = w_done || (m_w_valid && m_w_ready);

  assign m_r_ready = (state == cache_pkg::MEM_READ_WAIT);
  assign m_b_ready = (state == cache_pkg::MEM_WRITE_WAIT);

  assign m_ar = '{addr: req_q.addr, prot: 3'b000};
  assign m_aw = '{addr: req_q.addr, prot: 3'b000};
  assign m_w  = '{data: req_q.data, strb: req_q.strb};

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state      <= cache_pkg::MEM_IDLE;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      mrsp_valid <= 1'b0;
    end else begin
      if (mrsp_valid && mrsp_ready) begin
        mrsp_valid <= 1'b0;
      end
      case (state)
        cache_pkg::MEM_IDLE: begin
          if (mreq_valid && mreq_ready) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            state   <= cache_pkg::MEM_ADDR;
          end
        end
        cache_pkg::MEM_ADDR: begin
          if (!is_wr) begin
            if (m_ar_ready) begin
              state <= cache_pkg::MEM_READ_WAIT;
            end
          end else begin
            aw_done <= aw_fin;
            w_done  <= w_fin;
            if (aw_fin && w_fin) begin
              state <= cache_pkg::MEM_WRITE_WAIT;
            end
          end
        end
        cache_pkg::MEM_READ_WAIT: begin
          if (m_r_valid) begin
            mrsp_valid <= 1'b1;
            state      <= cache_pkg::MEM_IDLE;
          end
        end
        cache_pkg::MEM_WRITE_WAIT: begin
          // the B response code is not checked
          if (m_b_valid) begin
            mrsp_valid <= 1'b1;
            state      <= cache_pkg::MEM_IDLE;
          end
        end
        default: state <= cache_pkg::MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge ACLK) begin
    if (mreq_valid && mreq_ready) begin
      req_q <= mreq;
    end
    if (m_r_valid && m_r_ready) begin
      mrsp_data <= m_r.data;
    end
  end

  a_ar_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar));

endmodule

/* axil_cache.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module axil_cache (
  input  logic               ACLK,
  input  logic               ARESETn,
  input  logic               ar_valid,
  output logic               ar_ready,
  input  axil_pkg::axil_ax_t ar,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axil_pkg::axil_ax_t aw,
  input  logic               w_valid,
  output logic               w_ready,
  input  axil_pkg::axil_w_t  w,
  output logic               r_valid,
  input  logic               r_ready,
  output axil_pkg::axil_r_t  r,
  output logic               b_valid,
  input  logic               b_ready,
  output axil_pkg::axil_b_t  b,
  output logic               m_ar_valid,
  input  logic               m_ar_ready,
  output axil_pkg::axil_ax_t m_ar,
  output logic               m_aw_valid,
  input  logic               m_aw_ready,
  output axil_pkg::axil_ax_t m_aw,
  output logic               m_w_valid,
  input  logic               m_w_ready,
  output axil_pkg::axil_w_t  m_w,
  input  logic               m_r_valid,
  output logic               m_r_ready,
  input  axil_pkg::axil_r_t  m_r,
  input  logic               m_b_valid,
  output logic               m_b_ready,
  input  axil_pkg::axil_b_t  m_b
);

  logic                     req_valid;
  logic                     req_ready;
  cache_pkg::cache_req_t    req;
  logic                     rsp_valid;
  logic                     rsp_ready;
  cache_pkg::cache_rsp_t    rsp;
  logic                     mreq_valid;
  logic                     mreq_ready;
  cache_pkg::cache_req_t    mreq;
  logic                     mrsp_valid;
  logic                     mrsp_ready;
  logic [`CACHE_DATA_W-1:0] mrsp_data;

  cache_proc_port u_proc_port (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .aw        (aw),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .w         (w),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r         (r),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .b         (b),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  cache_ctrl u_ctrl (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req        (req),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .mreq_valid (mreq_valid),
    .mreq_ready (mreq_ready),
    .mreq       (mreq),
    .mrsp_valid (mrsp_valid),
    .mrsp_ready (mrsp_ready),
    .mrsp_data  (mrsp_data)
  );

  cache_mem_port u_mem_port (
    .ACLK       (ACLK),
    .ARESETn    (ARESETn),
    .mreq_valid (mreq_valid),
    .mreq_ready (mreq_ready),
    .mreq       (mreq),
    .mrsp_valid (mrsp_valid),
    .mrsp_ready (mrsp_ready),
    .mrsp_data  (mrsp_data),
    .m_ar_valid (m_ar_valid),
    .m_ar_ready (m_ar_ready),
    .m_ar       (m_ar),
    .m_aw_valid (m_aw_valid),
    .m_aw_ready (m_aw_ready),
    .m_aw       (m_aw),
    .m_w_valid  (m_w_valid),
    .m_w_ready  (m_w_ready),
    .m_w        (m_w),
    .m_r_valid  (m_r_valid),
    .m_r_ready  (m_r_ready),
    .m_r        (m_r),
    .m_b_valid  (m_b_valid),
    .m_b_ready  (m_b_ready),
    .m_b        (m_b)
  );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic ACLK,
  output logic ARESETn
);

  // 100 ns period
  initial begin
    ACLK = 1'b0;
    forever #50 ACLK = ~ACLK;
  end

  // low over the first two rising edges, released on a falling edge
  initial begin
    ARESETn = 1'b0;
    repeat (2) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;
  end

endmodule

/* tb_axil_cache.sv */
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_axil_cache;

  typedef logic [`CACHE_ADDR_W-1:0]   addr_t;
  typedef logic [`CACHE_DATA_W-1:0]   word_t;
  typedef logic [`CACHE_DATA_W/8-1:0] strb_t;

  localparam int mem_words = 256;
  localparam int max_wait  = 40;
  localparam int max_hold  = 8;
  localparam int mix_ops   = 40;
  localparam int total_ops = 2 + 3 + 2 + 6 + 2 + mix_ops;
  // accept wait, response wait and back-pressure of the slowest operation
  localparam int op_cycles   = 2 * max_wait + max_hold + 6;
  localparam int watchdog_ns = (total_ops * op_cycles + 10) * 100;

  logic               ACLK;
  logic               ARESETn;
  logic               ar_valid;
  logic               ar_ready;
  axil_pkg::axil_ax_t ar;
  logic               aw_valid;
  logic               aw_ready;
  axil_pkg::axil_ax_t aw;
  logic               w_valid;
  logic               w_ready;
  axil_pkg::axil_w_t  w;
  logic               r_valid;
  logic               r_ready;
  axil_pkg::axil_r_t  r;
  logic               b_valid;
  logic               b_ready;
  axil_pkg::axil_b_t  b;
  logic               m_ar_valid;
  logic               m_ar_ready;
  axil_pkg::axil_ax_t m_ar;
  logic               m_aw_valid;
  logic               m_aw_ready;
  axil_pkg::axil_ax_t m_aw;
  logic               m_w_valid;
  logic               m_w_ready;
  axil_pkg::axil_w_t  m_w;
  logic               m_r_valid;
  logic               m_r_ready;
  axil_pkg::axil_r_t  m_r;
  logic               m_b_valid;
  logic               m_b_ready;
  axil_pkg::axil_b_t  m_b;

  word_t mem [mem_words];
  word_t shadow [mem_words];
  int    mem_reads;
  int    mem_writes;
  int    test_errs;
  int    tests_passed;
  int    tests_failed;
  string cur_test;

  tb_clock_gen u_clk (
    .ACLK    (ACLK),
    .ARESETn (ARESETn)
  );

  axil_cache u_dut (.*);

  function automatic word_t fill_pattern(input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic int word_index(input addr_t addr);
    return int'(addr[9:2]);
  endfunction

  // bytes with a strobe bit come from the new word
  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input strb_t strb);
    word_t res;
    res = old_word;
    for (int i = 0; i < `CACHE_DATA_W/8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return res;
  endfunction

  // memory side subordinate with random ready and response delays
  initial begin : mem_model
    logic              rd_pend;
    logic              wr_pend;
    logic              aw_got;
    logic              w_got;
    logic              r_fire;
    logic              b_fire;
    addr_t             rd_addr;
    addr_t             wr_addr;
    axil_pkg::axil_w_t wr_beat;
    int                rd_delay;
    int                wr_delay;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_pattern(addr_t'(i) << 2);
    end
    mem_reads  = 0;
    mem_writes = 0;
    m_ar_ready = 1'b0;
    m_aw_ready = 1'b0;
    m_w_ready  = 1'b0;
    m_r_valid  = 1'b0;
    m_b_valid  = 1'b0;
    m_r        = '0;
    m_b        = '0;
    rd_pend    = 1'b0;
    wr_pend    = 1'b0;
    aw_got     = 1'b0;
    w_got      = 1'b0;
    r_fire     = 1'b0;
    b_fire     = 1'b0;
    rd_delay   = 0;
    wr_delay   = 0;
    forever begin
      @(negedge ACLK);
      // responses that went out on the last rising edge
      if (r_fire) begin
        m_r_valid = 1'b0;
        rd_pend   = 1'b0;
      end
      if (b_fire) begin
        m_b_valid = 1'b0;
        wr_pend   = 1'b0;
        aw_got    = 1'b0;
        w_got     = 1'b0;
      end
      // a ready raised here completes on the next rising edge
      m_ar_ready = m_ar_valid && !rd_pend && ($urandom_range(2, 0) != 0);
      if (m_ar_ready) begin
        rd_pend  = 1'b1;
        rd_addr  = m_ar.addr;
        rd_delay = $urandom_range(3, 0);
        mem_reads++;
        // prot from the processor side never reaches memory
        if (m_ar.prot !== 3'b000) begin
          report_mismatch(cur_test, '0, word_t'(m_ar.prot));
        end
      end
      m_aw_ready = m_aw_valid && !aw_got && ($urandom_range(2, 0) != 0);
      if (m_aw_ready) begin
        aw_got  = 1'b1;
        wr_addr = m_aw.addr;
        if (m_aw.prot !== 3'b000) begin
          report_mismatch(cur_test, '0, word_t'(m_aw.prot));
        end
      end
      m_w_ready = m_w_valid && !w_got && ($urandom_range(2, 0) != 0);
      if (m_w_ready) begin
        w_got   = 1'b1;
        wr_beat = m_w;
      end
      if (aw_got && w_got && !wr_pend) begin
        mem[wr_addr[9:2]] = merge_bytes(mem[wr_addr[9:2]], wr_beat.data, wr_beat.strb);
        wr_pend  = 1'b1;
        wr_delay = $urandom_range(3, 0);
        mem_writes++;
      end
      if (rd_pend && !m_r_valid && !m_ar_ready) begin
        if (rd_delay == 0) begin
          m_r_valid = 1'b1;
          m_r       = '{data: mem[rd_addr[9:2]], resp: axil_pkg::OKAY};
        end else begin
          rd_delay--;
        end
      end
      if (wr_pend && !m_b_valid && !m_aw_ready && !m_w_ready) begin
        if (wr_delay == 0) begin
          m_b_valid = 1'b1;
          m_b       = '{resp: axil_pkg::OKAY};
        end else begin
          wr_delay--;
        end
      end
      r_fire = m_r_valid && m_r_ready;
      b_fire = m_b_valid && m_b_ready;
    end
  end

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    test_errs++;
  endtask

  task automatic report_failure(input string name, input string what);
    $display("[ERROR] %s: %s", name, what);
    test_errs++;
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // lat counts falling edges from the AR transfer to r_valid
  task automatic read_word(input string name, input addr_t addr, input int hold,
                           output word_t data, output int lat);
    int n;
    cur_test = name;
    @(negedge ACLK);
    ar_valid = 1'b1;
    ar       = '{addr: addr, prot: 3'b101};
    n = 0;
    do begin
      @(negedge ACLK);
      n++;
    end while (ar_ready && n < max_wait);
    ar_valid = 1'b0;
    data     = 'x;
    lat      = 0;
    if (ar_ready) begin
      report_failure(name, "read address never accepted");
      return;
    end
    while (!r_valid && lat < max_wait) begin
      @(negedge ACLK);
      lat++;
    end
    if (!r_valid) begin
      report_failure(name, "no read response");
      return;
    end
    data = r.data;
    if (r.resp !== axil_pkg::OKAY) begin
      report_mismatch(name, word_t'(axil_pkg::OKAY), word_t'(r.resp));
    end
    repeat (hold) begin
      @(negedge ACLK);
      if (!r_valid) begin
        report_failure(name, "r_valid dropped while r_ready was low");
      end
      if (r.data !== data) begin
        report_mismatch(name, data, r.data);
      end
      if (ar_ready) begin
        report_failure(name, "ar_ready high before the R transfer");
      end
    end
    r_ready = 1'b1;
    @(negedge ACLK);
    r_ready = 1'b0;
    if (!ar_ready) begin
      report_failure(name, "ar_ready still low after the R transfer");
    end
  endtask

  task automatic write_word(input string name, input addr_t addr, input word_t data,
                            input strb_t strb, input int hold);
    int n;
    cur_test = name;
    @(negedge ACLK);
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    aw       = '{addr: addr, prot: 3'b011};
    w        = '{data: data, strb: strb};
    n = 0;
    do begin
      @(negedge ACLK);
      n++;
    end while (aw_ready && n < max_wait);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
    if (aw_ready) begin
      report_failure(name, "write never accepted");
      return;
    end
    n = 0;
    while (!b_valid && n < max_wait) begin
      @(negedge ACLK);
      n++;
    end
    if (!b_valid) begin
      report_failure(name, "no write response");
      return;
    end
    if (b.resp !== axil_pkg::OKAY) begin
      report_mismatch(name, word_t'(axil_pkg::OKAY), word_t'(b.resp));
    end
    repeat (hold) begin
      @(negedge ACLK);
      if (!b_valid) begin
        report_failure(name, "b_valid dropped while b_ready was low");
      end
      if (ar_ready) begin
        report_failure(name, "ar_ready high before the B transfer");
      end
    end
    b_ready = 1'b1;
    @(negedge ACLK);
    b_ready = 1'b0;
    if (!ar_ready) begin
      report_failure(name, "ar_ready still low after the B transfer");
    end
  endtask

  task automatic reset_values();
    string name = "reset values";
    if (!ar_ready || !aw_ready || !w_ready) begin
      report_failure(name, "a processor ready is low after reset");
    end
    if (r_valid || b_valid) begin
      report_failure(name, "a processor response is valid after reset");
    end
    if (m_ar_valid || m_aw_valid || m_w_valid || m_r_ready || m_b_ready) begin
      report_failure(name, "a memory side handshake is high after reset");
    end
    finish_test(name);
  endtask

  task automatic read_miss_then_hit();
    string name = "read miss then hit";
    addr_t addr = 32'h0000_0010;
    word_t data;
    int    lat;
    int    reads0;
    reads0 = mem_reads;
    read_word(name, addr, 0, data, lat);
    if (data !== shadow[word_index(addr)]) begin
      report_mismatch(name, shadow[word_index(addr)], data);
    end
    if (mem_reads != reads0 + 1) begin
      report_mismatch(name, reads0 + 1, mem_reads);
    end
    read_word(name, addr, 0, data, lat);
    if (data !== shadow[word_index(addr)]) begin
      report_mismatch(name, shadow[word_index(addr)], data);
    end
    if (mem_reads != reads0 + 1) begin
      report_mismatch(name, reads0 + 1, mem_reads);
    end
    if (lat != 2) begin
      report_mismatch(name, 2, lat);
    end
    finish_test(name);
  endtask

  task automatic write_hit_strobed();
    string name = "write hit with strobes";
    addr_t addr = 32'h0000_0024;
    word_t data;
    word_t exp;
    int    lat;
    int    reads0;
    int    writes0;
    read_word(name, addr, 0, data, lat);
    reads0  = mem_reads;
    writes0 = mem_writes;
    exp = merge_bytes(shadow[word_index(addr)], 32'h1122_3344, 4'b0101);
    shadow[word_index(addr)] = exp;
    write_word(name, addr, 32'h1122_3344, 4'b0101, 0);
    if (mem_writes != writes0 + 1) begin
      report_mismatch(name, writes0 + 1, mem_writes);
    end
    if (mem[word_index(addr)] !== exp) begin
      report_mismatch(name, exp, mem[word_index(addr)]);
    end
    read_word(name, addr, 0, data, lat);
    if (data !== exp) begin
      report_mismatch(name, exp, data);
    end
    if (mem_reads != reads0) begin
      report_mismatch(name, reads0, mem_reads);
    end
    finish_test(name);
  endtask

  task automatic write_miss_no_alloc();
    string name = "write miss without allocation";
    addr_t addr = 32'h0000_0038;
    word_t data;
    int    lat;
    int    reads0;
    int    writes0;
    writes0 = mem_writes;
    shadow[word_index(addr)] = 32'h5eed_c0de;
    write_word(name, addr, 32'h5eed_c0de, 4'hf, 0);
    if (mem_writes != writes0 + 1) begin
      report_mismatch(name, writes0 + 1, mem_writes);
    end
    if (mem[word_index(addr)] !== 32'h5eed_c0de) begin
      report_mismatch(name, 32'h5eed_c0de, mem[word_index(addr)]);
    end
    reads0 = mem_reads;
    read_word(name, addr, 0, data, lat);
    if (mem_reads != reads0 + 1) begin
      report_mismatch(name, reads0 + 1, mem_reads);
    end
    if (data !== 32'h5eed_c0de) begin
      report_mismatch(name, 32'h5eed_c0de, data);
    end
    finish_test(name);
  endtask

  // both addresses map to set 3 with different tags
  task automatic set_conflict();
    string name = "conflict";
    addr_t addrs [2] = '{32'h0000_000c, 32'h0000_010c};
    word_t data;
    int    lat;
    int    reads0;
    for (int round = 0; round < 3; round++) begin
      foreach (addrs[k]) begin
        reads0 = mem_reads;
        read_word(name, addrs[k], 0, data, lat);
        if (mem_reads != reads0 + 1) begin
          report_mismatch(name, reads0 + 1, mem_reads);
        end
        if (data !== shadow[word_index(addrs[k])]) begin
          report_mismatch(name, shadow[word_index(addrs[k])], data);
        end
      end
    end
    finish_test(name);
  endtask

  task automatic response_back_pressure();
    string name = "back-pressure";
    addr_t addr = 32'h0000_0014;
    word_t data;
    int    lat;
    read_word(name, addr, $urandom_range(max_hold, 1), data, lat);
    if (data !== shadow[word_index(addr)]) begin
      report_mismatch(name, shadow[word_index(addr)], data);
    end
    shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], 32'hcafe_f00d, 4'b1100);
    write_word(name, addr, 32'hcafe_f00d, 4'b1100, $urandom_range(max_hold, 1));
    if (mem[word_index(addr)] !== shadow[word_index(addr)]) begin
      report_mismatch(name, shadow[word_index(addr)], mem[word_index(addr)]);
    end
    finish_test(name);
  endtask

  // 32 words over 4 sets keep hits, misses and evictions mixed
  task automatic random_mix();
    string name = "random mix";
    addr_t addr;
    word_t data;
    strb_t strb;
    int    lat;
    repeat (mix_ops) begin
      addr = addr_t'($urandom_range(31, 0)) << 2;
      if ($urandom_range(1, 0) == 1) begin
        data = $urandom();
        strb = strb_t'($urandom_range(15, 0));
        shadow[word_index(addr)] = merge_bytes(shadow[word_index(addr)], data, strb);
        write_word(name, addr, data, strb, $urandom_range(2, 0));
      end else begin
        read_word(name, addr, $urandom_range(2, 0), data, lat);
        if (data !== shadow[word_index(addr)]) begin
          report_mismatch(name, shadow[word_index(addr)], data);
        end
      end
    end
    for (int i = 0; i < 32; i++) begin
      if (mem[i] !== shadow[i]) begin
        report_mismatch(name, shadow[i], mem[i]);
      end
    end
    finish_test(name);
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    $display("[ERROR] watchdog expired after %0d ns with tests still running", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    void'($urandom(32'h8a0f_f4ae));
    ar_valid = 1'b0;
    ar       = '0;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      shadow[i] = fill_pattern(addr_t'(i) << 2);
    end
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    wait (ARESETn === 1'b1);
    @(negedge ACLK);
    reset_values();
    read_miss_then_hit();
    write_hit_strobed();
    write_miss_no_alloc();
    set_conflict();
    response_back_pressure();
    random_mix();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+.
axil_pkg.sv
cache_pkg.sv
cache_proc_port.sv
cache_store.sv
cache_ctrl.sv
cache_mem_port.sv
axil_cache.sv
tb_clock_gen.sv
tb_axil_cache.sv

/* Bender.yml */
package:
  name: axil_cache

export_include_dirs:
  - .

sources:
  - axil_pkg.sv
  - cache_pkg.sv
  - cache_proc_port.sv
  - cache_store.sv
  - cache_ctrl.sv
  - cache_mem_port.sv
  - axil_cache.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_axil_cache.sv
